// File: Bender.yml
package:
  name: i2c_master

sources:
  - src/i2c_pkg.sv
  - src/i2c_bit_timer.sv
  - src/i2c_sequencer.sv
  - src/i2c_serdes.sv
  - src/i2c_master_top.sv
  - target: test
    files:
      - test/i2c_slave_model.sv
      - test/i2c_master_tb.sv

// File: i2c_master.f
src/i2c_pkg.sv
src/i2c_bit_timer.sv
src/i2c_sequencer.sv
src/i2c_serdes.sv
src/i2c_master_top.sv
test/i2c_slave_model.sv
test/i2c_master_tb.sv

// File: src/i2c_bit_timer.sv
//==============================
// i2c bit timer
// scl divider, scl output, mid-high and mid-low strobes
//==============================

`timescale 1ns/1ps

module i2c_bit_timer
    import i2c_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic run_i,
    output logic scl_o,
    output logic scl_high_o,
    output logic scl_low_o
);

    logic [SCL_CNT_W-1:0] scl_cnt;

    // divider, parked at zero while idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_cnt <= '0;
        end else if (!run_i || (scl_cnt == SCL_CNT_W'(SCL_CLK_CNT - 1))) begin
            scl_cnt <= '0;
        end else begin
            scl_cnt <= scl_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_o <= 1'b1;
        end else if (scl_cnt == SCL_CNT_W'(SCL_CLK_CNT / 2)) begin
            scl_o <= 1'b0;      // falls at half period
        end else if (scl_cnt == '0) begin
            scl_o <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_high_o <= 1'b0;
            scl_low_o  <= 1'b0;
        end else begin
            scl_high_o <= (scl_cnt == SCL_CNT_W'(SCL_CLK_CNT / 4));
            scl_low_o  <= (scl_cnt == SCL_CNT_W'(3 * SCL_CLK_CNT / 4));
        end
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(scl_high_o && scl_low_o));

endmodule

// File: src/i2c_master_top.sv
//==============================
// i2c master top level
// bit timer, sequencer and serdes
//==============================

`timescale 1ns/1ps

module i2c_master_top
    import i2c_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  i2c_cmd_t   cmd_i,
    input  logic [7:0] wdata_i,
    input  logic       sda_i,
    output i2c_pad_t   pad_o,
    output logic       ready_o,
    output logic       done_o,
    output logic       error_o,
    output logic       wvalid_o,
    output logic [7:0] rdata_o,
    output logic       rvalid_o
);

    logic         run;
    logic         scl;
    logic         scl_high;
    logic         scl_low;
    logic         sda_o;
    logic         sda_en;
    i2c_bus_ctl_t bus_ctl;

    assign pad_o = '{scl: scl, sda_o: sda_o, sda_en: sda_en};

    i2c_bit_timer u_bit_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .run_i      (run),
        .scl_o      (scl),
        .scl_high_o (scl_high),
        .scl_low_o  (scl_low)
    );

    i2c_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_i      (cmd_i),
        .wdata_i    (wdata_i),
        .sda_i      (sda_i),
        .scl_i      (scl),
        .scl_high_i (scl_high),
        .scl_low_i  (scl_low),
        .run_o      (run),
        .bus_ctl_o  (bus_ctl),
        .ready_o    (ready_o),
        .done_o     (done_o),
        .error_o    (error_o),
        .wvalid_o   (wvalid_o)
    );

    i2c_serdes u_serdes (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_ctl_i  (bus_ctl),
        .sda_i      (sda_i),
        .scl_high_i (scl_high),
        .scl_low_i  (scl_low),
        .sda_o      (sda_o),
        .sda_en_o   (sda_en),
        .rdata_o    (rdata_o),
        .rvalid_o   (rvalid_o)
    );

endmodule

// File: src/i2c_pkg.sv
//==============================
// shared definitions for the i2c master
// bus-rate constants, transfer state enum
// command, bus control and pad structs
// address byte union
//==============================

package i2c_pkg;

    //==============================
    // bus timing
    localparam int SYS_CLOCK       = 50_000_000;
    localparam int SCL_CLOCK       = 400_000;
    localparam int SCL_CLK_CNT     = SYS_CLOCK / SCL_CLOCK;    // clk per scl period
    localparam int SCL_CNT_W       = $clog2(SCL_CLK_CNT);
    localparam int BUS_FREE_CYCLES = 2 * SCL_CLK_CNT;          // two scl periods
    localparam int SLOT_LAST       = 17;                       // 8 bits x 2 + ack x 2

    typedef enum logic [3:0] {
        IDLE, READY, W_START, R_START, D_ADDR_W, D_ADDR_R, W_ADDR, WR_DATA, RD_DATA, STOP
    } i2c_state_e;

    // byte counts are n-1 encoded
    typedef struct packed {
        logic       wen;
        logic       ren;
        logic [6:0] dev_addr;
        logic [7:0] word_addr;
        logic [7:0] num_data_w;
        logic [7:0] num_data_r;
    } i2c_cmd_t;

    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [6:0] dev_addr;
            logic       rw;         // 1 = read
        } f;
    } i2c_addr_byte_u;

    typedef struct packed {
        i2c_state_e state;
        logic [4:0] slot;
        logic [7:0] tx_byte;
        logic       last_read;      // final byte of a read, master NACKs it
    } i2c_bus_ctl_t;

    typedef struct packed {
        logic scl;
        logic sda_o;
        logic sda_en;
    } i2c_pad_t;

endpackage

// File: src/i2c_sequencer.sv
//==============================
// i2c transfer sequencer
// command latch, transfer fsm, slot / byte counters
// ack check, ready / done / error / wvalid
//==============================

`timescale 1ns/1ps

module i2c_sequencer
    import i2c_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  i2c_cmd_t     cmd_i,
    input  logic [7:0]   wdata_i,
    input  logic         sda_i,
    input  logic         scl_i,
    input  logic         scl_high_i,
    input  logic         scl_low_i,
    output logic         run_o,
    output i2c_bus_ctl_t bus_ctl_o,
    output logic         ready_o,
    output logic         done_o,
    output logic         error_o,
    output logic         wvalid_o
);

    i2c_state_e         state;
    i2c_state_e         next_state;
    i2c_cmd_t           cmd_q;
    i2c_addr_byte_u     addr_byte;
    logic [4:0]         slot;
    logic [SCL_CNT_W:0] free_cnt;
    logic [7:0]         wr_left;
    logic [7:0]         rd_left;
    logic               accept;
    logic               byte_state;
    logic               ack_slot;
    logic               nack;

    assign accept     = (state == READY) && ready_o && (cmd_i.wen || cmd_i.ren);
    assign byte_state = state inside {D_ADDR_W, D_ADDR_R, W_ADDR, WR_DATA, RD_DATA};
    assign ack_slot   = byte_state && scl_high_i && (slot == 5'(SLOT_LAST));
    assign nack       = ack_slot && sda_i && (state != RD_DATA);  // no slave ack on reads
    assign run_o      = !(state inside {IDLE, READY});

    //==============================
    // fsm
    always_comb begin
        next_state = state;
        case (state)
            IDLE:     if (free_cnt == (SCL_CNT_W + 1)'(BUS_FREE_CYCLES - 1)) next_state = READY;
            READY:    if (accept) next_state = W_START;
            W_START:  if (!scl_i) next_state = D_ADDR_W;     // start already on the bus
            R_START:  if (scl_high_i) next_state = D_ADDR_R;
            D_ADDR_W: if (ack_slot) next_state = nack ? IDLE : W_ADDR;
            D_ADDR_R: if (ack_slot) next_state = nack ? IDLE : RD_DATA;
            W_ADDR: begin
                if (ack_slot) begin
                    if (nack) next_state = IDLE;
                    else      next_state = cmd_q.wen ? WR_DATA : R_START;
                end
            end
            WR_DATA: begin
                if (ack_slot) begin
                    if (nack) next_state = IDLE;
                    else      next_state = (wr_left == '0) ? STOP : WR_DATA;
                end
            end
            RD_DATA:  if (ack_slot) next_state = (rd_left == '0) ? STOP : RD_DATA;
            STOP:     if (scl_high_i) next_state = IDLE;
            default:  next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            free_cnt <= '0;
            slot     <= '0;
            wr_left  <= '0;
            rd_left  <= '0;
        end else begin
            state    <= next_state;
            free_cnt <= (state == IDLE) ? free_cnt + 1'b1 : '0;
            if (!byte_state) begin
                slot <= '0;
            end else if (scl_high_i || scl_low_i) begin
                slot <= (slot == 5'(SLOT_LAST)) ? 5'd0 : slot + 5'd1;
            end
            if (accept) begin
                wr_left <= cmd_i.num_data_w;
                rd_left <= cmd_i.num_data_r;
            end else if (ack_slot && !nack) begin
                if ((state == WR_DATA) && (wr_left != '0)) wr_left <= wr_left - 8'd1;
                if ((state == RD_DATA) && (rd_left != '0)) rd_left <= rd_left - 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) cmd_q <= cmd_i;
    end

    //==============================
    // status pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_o  <= 1'b0;
            done_o   <= 1'b0;
            error_o  <= 1'b0;
            wvalid_o <= 1'b0;
        end else begin
            ready_o  <= (state == READY) && !accept;
            done_o   <= (state == STOP) && scl_high_i;
            error_o  <= nack;
            wvalid_o <= ack_slot && !nack && (state == WR_DATA);
        end
    end

    // byte on the wire for the serdes
    always_comb begin
        addr_byte.f.dev_addr = cmd_q.dev_addr;
        addr_byte.f.rw       = (state == D_ADDR_R);
        bus_ctl_o.state      = state;
        bus_ctl_o.slot       = slot;
        bus_ctl_o.last_read  = (state == RD_DATA) && (rd_left == '0);
        case (state)
            D_ADDR_W, D_ADDR_R: bus_ctl_o.tx_byte = addr_byte.raw;
            W_ADDR:             bus_ctl_o.tx_byte = cmd_q.word_addr;
            WR_DATA:            bus_ctl_o.tx_byte = wdata_i;
            default:            bus_ctl_o.tx_byte = '0;
        endcase
    end

    a_done_err_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(done_o && error_o));

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {IDLE, READY, W_START, R_START, D_ADDR_W, D_ADDR_R,
                      W_ADDR, WR_DATA, RD_DATA, STOP});

endmodule

// File: src/i2c_serdes.sv
//==============================
// i2c bit serializer / deserializer
// sda driver and enable, read shift register
// rdata / rvalid
//==============================

`timescale 1ns/1ps

module i2c_serdes
    import i2c_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  i2c_bus_ctl_t bus_ctl_i,
    input  logic         sda_i,
    input  logic         scl_high_i,
    input  logic         scl_low_i,
    output logic         sda_o,
    output logic         sda_en_o,
    output logic [7:0]   rdata_o,
    output logic         rvalid_o
);

    logic [7:0] shift_q;
    logic       ack_slot;
    logic       tx_bit;

    assign ack_slot = (bus_ctl_i.slot == 5'(SLOT_LAST - 1));
    assign tx_bit   = bus_ctl_i.tx_byte[3'd7 - bus_ctl_i.slot[3:1]];   // msb first

    //==============================
    // sda output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sda_o    <= 1'b1;
            sda_en_o <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= 1'b0;
            case (bus_ctl_i.state)
                W_START: begin
                    sda_en_o <= 1'b1;
                    if (scl_high_i) sda_o <= 1'b0;      // start
                end
                R_START: begin
                    if (scl_low_i) begin
                        sda_o    <= 1'b1;
                        sda_en_o <= 1'b1;
                    end else if (scl_high_i) begin
                        sda_o <= 1'b0;                  // repeated start
                    end
                end
                D_ADDR_W, D_ADDR_R, W_ADDR, WR_DATA: begin
                    if (scl_low_i) begin
                        sda_en_o <= !ack_slot;          // slave acks here
                        sda_o    <= ack_slot ? 1'b1 : tx_bit;
                    end
                end
                RD_DATA: begin
                    if (scl_low_i) begin
                        sda_en_o <= ack_slot;
                        sda_o    <= ack_slot ? bus_ctl_i.last_read : 1'b1;
                        rvalid_o <= ack_slot;
                    end
                end
                STOP: begin
                    if (scl_low_i) begin
                        sda_o    <= 1'b0;
                        sda_en_o <= 1'b1;
                    end else if (scl_high_i) begin
                        sda_o <= 1'b1;                  // stop
                    end
                end
                default: sda_en_o <= 1'b0;
            endcase
        end
    end

    // read path
    always_ff @(posedge clk) begin
        if ((bus_ctl_i.state == RD_DATA) && scl_high_i && bus_ctl_i.slot[0] && !bus_ctl_i.slot[4])
            shift_q <= {shift_q[6:0], sda_i};
        if ((bus_ctl_i.state == RD_DATA) && scl_low_i && ack_slot)
            rdata_o <= shift_q;
    end

    a_sda_scl_low: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(sda_o) |-> $past(scl_low_i) ||
                            ($past(bus_ctl_i.state) inside {W_START, R_START, STOP}));

endmodule

// File: test/i2c_master_tb.sv
//==============================
// testbench for the i2c master
// clock, reset, stimulus table and checks
// memory slave on a wired-and sda line
//==============================

`timescale 1ns/1ps

module i2c_master_tb
    import i2c_pkg::*;
();

    localparam int         NUM_ROWS      = 8;
    localparam int         READY_TIMEOUT = 2000;
    localparam int         XFER_TIMEOUT  = 20000;
    localparam logic [7:0] MEM_FILL_XOR  = 8'h5a;

    typedef struct packed {
        logic            rd;        // 0 = write
        logic [6:0]      dev;
        logic [7:0]      waddr;
        logic [2:0]      cnt;       // bytes moved minus one
        logic [7:0][7:0] data;      // data[0] goes first
        logic            rnd;       // random write or its read-back
        logic            err;       // nack expected
    } row_t;

    logic        clk;
    logic        rst_n;
    i2c_cmd_t    cmd_i;
    logic [7:0]  wdata_i;
    i2c_pad_t    pad;
    logic        sda_bus;
    logic        slave_sda;
    logic        ready;
    logic        done;
    logic        err;
    logic        wvalid;
    logic        rvalid;
    logic [7:0]  rdata;
    logic [7:0]  ref_mem [256];
    logic [7:0]  rand_addr;
    row_t        rows [NUM_ROWS];
    int unsigned seed_val;

    always #4 clk = ~clk;

    assign sda_bus = !(pad.sda_en && !pad.sda_o) && slave_sda;     // open drain with pull-up

    i2c_master_top u_i2c_master_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_i    (cmd_i),
        .wdata_i  (wdata_i),
        .sda_i    (sda_bus),
        .pad_o    (pad),
        .ready_o  (ready),
        .done_o   (done),
        .error_o  (err),
        .wvalid_o (wvalid),
        .rdata_o  (rdata),
        .rvalid_o (rvalid)
    );

    i2c_slave_model #(.DEV_ADDR(7'h50), .FILL_XOR(MEM_FILL_XOR)) u_slave (
        .clk   (clk),
        .rst_n (rst_n),
        .scl_i (pad.scl),
        .sda_i (sda_bus),
        .sda_o (slave_sda)
    );

    //==============================
    // helpers
    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, act);
        abort_run();
    endtask

    task automatic timed_out(input string what);
        $display("no response: timed out waiting for %s", what);
        abort_run();
    endtask

    function automatic row_t make_row(input logic rd, input logic [6:0] dev,
                                      input logic [7:0] waddr, input logic [2:0] cnt,
                                      input logic [63:0] data, input logic rnd,
                                      input logic err_exp);
        row_t r;
        r.rd    = rd;
        r.dev   = dev;
        r.waddr = waddr;
        r.cnt   = cnt;
        r.data  = data;
        r.rnd   = rnd;
        r.err   = err_exp;
        return r;
    endfunction

    // no strobes may fire while the bus is idle
    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!ready) begin
            @(negedge clk);
            waited++;
            if (waited > READY_TIMEOUT) timed_out("ready_o");
            assert ({done, err, wvalid, rvalid} == 4'b0)
                else mismatch("{done_o,error_o,wvalid_o,rvalid_o}", 0,
                              {done, err, wvalid, rvalid});
        end
    endtask

    task automatic run_row(input row_t r);
        logic [7:0] wa;
        logic [7:0] addr;
        logic [7:0] bytes [8];
        int         n;
        int         waited;
        int         wv_cnt;
        int         rv_cnt;
        int         done_cnt;
        int         err_cnt;
        int         exp_wv;
        int         exp_rv;
        wa       = r.waddr;
        n        = int'(r.cnt) + 1;
        wv_cnt   = 0;
        rv_cnt   = 0;
        done_cnt = 0;
        err_cnt  = 0;
        for (int i = 0; i < 8; i++) bytes[i] = r.data[i];
        if (r.rnd && !r.rd) begin
            wa        = 8'($urandom);
            rand_addr = wa;
            for (int i = 0; i < 8; i++) bytes[i] = 8'($urandom);
        end else if (r.rnd) begin
            wa = rand_addr;
        end
        wait_ready();
        cmd_i.wen        = !r.rd;
        cmd_i.ren        = r.rd;
        cmd_i.dev_addr   = r.dev;
        cmd_i.word_addr  = wa;
        cmd_i.num_data_w = r.rd ? 8'd0 : 8'(r.cnt);
        cmd_i.num_data_r = r.rd ? 8'(r.cnt) : 8'd0;
        wdata_i          = bytes[0];
        @(negedge clk);
        cmd_i.wen = 1'b0;
        cmd_i.ren = 1'b0;
        waited    = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > XFER_TIMEOUT) timed_out("done_o or error_o");
            if (wvalid) begin
                wv_cnt++;
                if (wv_cnt < n) wdata_i = bytes[wv_cnt];   // next byte for the wire
            end
            if (rvalid) begin
                addr = wa + 8'(rv_cnt);
                assert (rdata == ref_mem[addr]) else mismatch("rdata_o", ref_mem[addr], rdata);
                rv_cnt++;
            end
            if (done) done_cnt++;
            if (err) err_cnt++;
        end while (!done && !err);
        exp_wv = (r.rd || r.err) ? 0 : n;
        exp_rv = (r.rd && !r.err) ? n : 0;
        assert (err_cnt == int'(r.err)) else mismatch("error_o pulses", r.err, err_cnt);
        assert (done_cnt == int'(!r.err)) else mismatch("done_o pulses", !r.err, done_cnt);
        assert (wv_cnt == exp_wv) else mismatch("wvalid_o pulses", exp_wv, wv_cnt);
        assert (rv_cnt == exp_rv) else mismatch("rvalid_o pulses", exp_rv, rv_cnt);
        if (!r.rd && !r.err) begin
            for (int i = 0; i < n; i++) begin
                addr = wa + 8'(i);
                assert (u_slave.mem[addr] == bytes[i])
                    else mismatch("slave mem", bytes[i], u_slave.mem[addr]);
                ref_mem[addr] = bytes[i];
            end
        end
    endtask

    //==============================
    // main sequence
    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        cmd_i    = '0;
        wdata_i  = '0;
        seed_val = $urandom(32'he2bd);
        for (int i = 0; i < 256; i++) ref_mem[i] = 8'(i) ^ MEM_FILL_XOR;
        rows[0] = make_row(1'b0, 7'h50, 8'h10, 3'd0, 64'h3c, 1'b0, 1'b0);
        rows[1] = make_row(1'b0, 7'h50, 8'h20, 3'd3, 64'hc4b3a291, 1'b0, 1'b0);
        rows[2] = make_row(1'b1, 7'h50, 8'h1e, 3'd5, 64'h0, 1'b0, 1'b0);  // fill + written
        rows[3] = make_row(1'b0, 7'h23, 8'h00, 3'd1, 64'h6655, 1'b0, 1'b1);
        rows[4] = make_row(1'b1, 7'h51, 8'h10, 3'd0, 64'h0, 1'b0, 1'b1);
        rows[5] = make_row(1'b1, 7'h50, 8'h10, 3'd0, 64'h0, 1'b0, 1'b0);
        rows[6] = make_row(1'b0, 7'h50, 8'h00, 3'd7, 64'h0, 1'b1, 1'b0);
        rows[7] = make_row(1'b1, 7'h50, 8'h00, 3'd7, 64'h0, 1'b1, 1'b0);
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (pad.scl == 1'b1) else mismatch("pad_o.scl", 1, pad.scl);
        assert (pad.sda_o == 1'b1) else mismatch("pad_o.sda_o", 1, pad.sda_o);
        assert (pad.sda_en == 1'b0) else mismatch("pad_o.sda_en", 0, pad.sda_en);
        assert ({ready, done, err, wvalid, rvalid} == 5'b0)
            else mismatch("{ready_o,done_o,error_o,wvalid_o,rvalid_o}", 0,
                          {ready, done, err, wvalid, rvalid});
        wait_ready();
        repeat (50) begin
            @(negedge clk);
            assert (ready) else mismatch("ready_o", 1, ready);
        end
        for (int i = 0; i < NUM_ROWS; i++) run_row(rows[i]);
        wait_ready();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: test/i2c_slave_model.sv
//==============================
// behavioral i2c memory slave
// 256-byte array, auto-increment word pointer
// oversamples scl / sda on clk
//==============================

`timescale 1ns/1ps

module i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR = 7'h50,
    parameter logic [7:0] FILL_XOR = 8'h5a
) (
    input  logic clk,
    input  logic rst_n,
    input  logic scl_i,
    input  logic sda_i,
    output logic sda_o      // 0 pulls the bus low
);

    typedef enum logic [2:0] {S_IDLE, S_ADDR, S_WORD, S_WDATA, S_RDATA} slave_state_e;

    slave_state_e state;
    logic [7:0]   mem [256];
    logic [7:0]   ptr;
    logic [7:0]   shift_q;
    logic [7:0]   tx_q;
    logic [3:0]   bit_cnt;      // scl rises in the current byte
    logic         rw_q;
    logic         master_ack;
    logic         scl_q;
    logic         sda_q;
    logic         scl_rise;
    logic         scl_fall;
    logic         start_seen;
    logic         stop_seen;

    assign scl_rise   = scl_i && !scl_q;
    assign scl_fall   = !scl_i && scl_q;
    assign start_seen = scl_i && scl_q && sda_q && !sda_i;
    assign stop_seen  = scl_i && scl_q && !sda_q && sda_i;

    initial begin
        for (int i = 0; i < 256; i++) mem[i] = 8'(i) ^ FILL_XOR;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            sda_o      <= 1'b1;
            ptr        <= '0;
            shift_q    <= '0;
            tx_q       <= '0;
            bit_cnt    <= '0;
            rw_q       <= 1'b0;
            master_ack <= 1'b0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
        end else begin
            scl_q <= scl_i;
            sda_q <= sda_i;
            if (start_seen) begin
                state   <= S_ADDR;
                bit_cnt <= '0;
                sda_o   <= 1'b1;
            end else if (stop_seen) begin
                state <= S_IDLE;
                sda_o <= 1'b1;
            end else if (state != S_IDLE && scl_rise) begin
                if (bit_cnt < 4'd8) shift_q <= {shift_q[6:0], sda_i};
                else                master_ack <= !sda_i;
                bit_cnt <= bit_cnt + 4'd1;
            end else if (state == S_RDATA && scl_fall) begin
                if (bit_cnt < 4'd8) begin
                    sda_o <= tx_q[3'd7 - bit_cnt[2:0]];
                end else if (bit_cnt == 4'd8) begin
                    sda_o <= 1'b1;              // master acks here
                end else if (master_ack) begin
                    tx_q    <= mem[ptr];
                    sda_o   <= mem[ptr][7];
                    ptr     <= ptr + 8'd1;
                    bit_cnt <= '0;
                end else begin
                    state <= S_IDLE;
                    sda_o <= 1'b1;
                end
            end else if (state != S_IDLE && scl_fall && bit_cnt == 4'd8) begin
                case (state)
                    S_ADDR: begin
                        if (shift_q[7:1] == DEV_ADDR) begin
                            rw_q  <= shift_q[0];
                            sda_o <= 1'b0;
                        end else begin
                            state <= S_IDLE;    // not ours
                        end
                    end
                    S_WORD: begin
                        ptr   <= shift_q;
                        sda_o <= 1'b0;
                    end
                    default: begin
                        mem[ptr] <= shift_q;
                        ptr      <= ptr + 8'd1;
                        sda_o    <= 1'b0;
                    end
                endcase
            end else if (state != S_IDLE && scl_fall && bit_cnt == 4'd9) begin
                sda_o   <= 1'b1;
                bit_cnt <= '0;
                if (state == S_ADDR && rw_q) begin
                    state <= S_RDATA;
                    tx_q  <= mem[ptr];
                    sda_o <= mem[ptr][7];
                    ptr   <= ptr + 8'd1;
                end else if (state == S_ADDR) begin
                    state <= S_WORD;
                end else if (state == S_WORD) begin
                    state <= S_WDATA;
                end
            end
        end
    end

endmodule
